// ==== core_pkg.sv ====
/*
 * Shared widths and types of the channelised integer core.
 * The datapath is 16-bit integer only and the register file holds four banks.
 * Opcode values 8 to 15 are illegal and raise the fault status.
 */
`default_nettype none

package core_pkg;

    ////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////
    localparam int data_w       = 16;
    localparam int reg_per_ch   = 16;
    localparam int reg_w        = 4;
    localparam int max_channels = 4;
    localparam int ch_w         = 2;
    localparam int istore_depth = 64;
    localparam int pc_w         = 6;

    // Cycles between the last fetch and the done pulse, less the writeback edge
    localparam int pipe_drain   = 3;

    ////////////////////////////////////////
    // Types
    ////////////////////////////////////////
    typedef logic [data_w-1:0] data_t;

    typedef struct packed {
        logic [ch_w-1:0]  channel;
        logic [reg_w-1:0] index;
    } reg_addr_t;

    typedef enum logic [3:0] {
        NOP = 4'd0,
        LDI = 4'd1,
        ADD = 4'd2,
        SUB = 4'd3,
        AND = 4'd4,
        OR  = 4'd5,
        XOR = 4'd6,
        SHL = 4'd7
    } opcode_e;

    // Opcode kept as raw bits so that illegal values survive the store
    typedef struct packed {
        logic [3:0]       opcode;
        logic [reg_w-1:0] dest;
        logic [reg_w-1:0] src_a;
        logic [reg_w-1:0] src_b;
        data_t            imm;
    } instr_t;

    typedef struct packed {
        logic            valid;
        logic [ch_w-1:0] channel;
    } fetch_t;

    typedef struct packed {
        logic      valid;
        opcode_e   opcode;
        reg_addr_t dest;
        data_t     operand_a;
        data_t     operand_b;
        data_t     imm;
    } op_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t addr;
        data_t     data;
    } wb_t;

endpackage

`default_nettype wire

// ==== core_control.sv ====
/*
 * Program sequencer. Each instruction is fetched once per active channel
 * before the pc moves on. n_channels and program_size are sampled live and
 * must stay stable while busy. n_channels of 0 behaves as 1.
 */
`default_nettype none

module core_control import core_pkg::*; (
    input  wire logic            clock,
    input  wire logic            arst_n,
    input  wire logic            run,
    input  wire logic [ch_w:0]   n_channels,
    input  wire logic [pc_w:0]   program_size,
    input  wire logic            illegal,
    output logic      [pc_w-1:0] istore_addr,
    output fetch_t               fetch,
    output logic                 busy,
    output logic                 done,
    output logic                 fault
);

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        DRAIN
    } state_e;

    state_e          state;
    logic [pc_w-1:0] pc;
    logic [ch_w-1:0] ch;
    logic [1:0]      drain_cnt;
    logic            last_ch;
    logic            last_pc;

    assign last_ch     = ({1'b0, ch} + 1'b1) >= n_channels;
    assign last_pc     = ({1'b0, pc} + 1'b1) >= program_size;
    assign istore_addr = pc;
    assign busy        = (state != IDLE);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state     <= IDLE;
            pc        <= '0;
            ch        <= '0;
            drain_cnt <= '0;
            fetch     <= '0;
            done      <= 1'b0;
            fault     <= 1'b0;
        end else begin
            done          <= 1'b0;
            // Tag travels beside the word the store returns next cycle
            fetch.valid   <= (state == FETCH);
            fetch.channel <= ch;
            case (state)
                IDLE: begin
                    if (run) begin
                        pc        <= '0;
                        ch        <= '0;
                        drain_cnt <= 2'(pipe_drain - 1);
                        state     <= (program_size == '0) ? DRAIN : FETCH;
                    end
                end
                FETCH: begin
                    drain_cnt <= 2'(pipe_drain - 1);
                    if (last_ch) begin
                        ch <= '0;
                        if (last_pc) begin
                            state <= DRAIN;
                        end else begin
                            pc <= pc + 1'b1;
                        end
                    end else begin
                        ch <= ch + 1'b1;
                    end
                end
                DRAIN: begin
                    // Last writeback lands at the edge that leaves this state
                    if (drain_cnt == '0) begin
                        state <= IDLE;
                        done  <= 1'b1;
                    end else begin
                        drain_cnt <= drain_cnt - 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
            // Sticky until the next accepted run
            if (state == IDLE && run) begin
                fault <= 1'b0;
            end else if (illegal) begin
                fault <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== core_istore.sv ====
/*
 * Instruction memory with a host write port and one registered fetch read.
 * Host writes are only legal while the core is idle. Contents are not reset.
 */
`default_nettype none

module core_istore import core_pkg::*; (
    input  wire logic            clock,
    input  wire logic            prog_wr,
    input  wire logic [pc_w-1:0] prog_addr,
    input  wire instr_t          prog_data,
    input  wire logic [pc_w-1:0] fetch_addr,
    output instr_t               fetch_word
);

    instr_t mem [istore_depth];

    always_ff @(posedge clock) begin
        if (prog_wr) begin
            mem[prog_addr] <= prog_data;
        end
    end

    // One cycle fetch latency
    always_ff @(posedge clock) begin
        fetch_word <= mem[fetch_addr];
    end

endmodule

`default_nettype wire

// ==== core_decode.sv ====
/*
 * Decode stage. Splits the fetched word, reads both operands from the
 * register file combinationally and registers them into op_t.
 * Illegal opcodes are dropped and reported with a one-cycle strobe.
 */
`default_nettype none

module core_decode import core_pkg::*; (
    input  wire logic   clock,
    input  wire logic   arst_n,
    input  wire fetch_t fetch,
    input  wire instr_t word,
    output reg_addr_t   read_addr_a,
    output reg_addr_t   read_addr_b,
    input  wire data_t  read_data_a,
    input  wire data_t  read_data_b,
    output op_t         op,
    output logic        illegal
);

    logic      legal;
    logic      valid_q;
    opcode_e   opcode_q;
    reg_addr_t dest_q;
    data_t     operand_a_q;
    data_t     operand_b_q;
    data_t     imm_q;

    // Register addresses are qualified by the channel of this fetch
    assign read_addr_a = '{channel: fetch.channel, index: word.src_a};
    assign read_addr_b = '{channel: fetch.channel, index: word.src_b};

    assign legal = (word.opcode <= SHL);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
            illegal <= 1'b0;
        end else begin
            valid_q <= fetch.valid && legal;
            illegal <= fetch.valid && !legal;
        end
    end

    ////////////////////////////////////////
    // Operand payload
    ////////////////////////////////////////
    always_ff @(posedge clock) begin
        opcode_q    <= opcode_e'(word.opcode);
        dest_q      <= '{channel: fetch.channel, index: word.dest};
        operand_a_q <= read_data_a;
        operand_b_q <= read_data_b;
        imm_q       <= word.imm;
    end

    assign op = '{
        valid:     valid_q,
        opcode:    opcode_q,
        dest:      dest_q,
        operand_a: operand_a_q,
        operand_b: operand_b_q,
        imm:       imm_q
    };

endmodule

`default_nettype wire

// ==== core_regfile.sv ====
/*
 * Channelised register file, 16 registers in each of 4 banks.
 * Writes happen at the clock edge and all reads are combinational.
 * Writeback wins over a host write. Contents are not reset.
 */
`default_nettype none

module core_regfile import core_pkg::*; (
    input  wire logic      clock,
    input  wire wb_t       wb,
    input  wire reg_addr_t read_addr_a,
    input  wire reg_addr_t read_addr_b,
    output data_t          read_data_a,
    output data_t          read_data_b,
    input  wire logic      host_wr,
    input  wire reg_addr_t host_addr,
    input  wire data_t     host_wdata,
    output data_t          host_rdata
);

    // Channel field is the upper part of the flat index
    data_t regs [max_channels*reg_per_ch];

    always_ff @(posedge clock) begin
        if (wb.valid) begin
            regs[wb.addr] <= wb.data;
        end else if (host_wr) begin
            regs[host_addr] <= host_wdata;
        end
    end

    ////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////
    assign read_data_a = regs[read_addr_a];
    assign read_data_b = regs[read_addr_b];
    assign host_rdata  = regs[host_addr];

endmodule

`default_nettype wire

// ==== core_execute.sv ====
/*
 * Integer ALU stage. Results wrap modulo 2^16 and SHL uses the low
 * four bits of operand b. NOP produces no writeback.
 */
`default_nettype none

module core_execute import core_pkg::*; (
    input  wire logic clock,
    input  wire logic arst_n,
    input  wire op_t  op,
    output wb_t       wb
);

    data_t     result;
    logic      valid_q;
    reg_addr_t addr_q;
    data_t     data_q;

    always_comb begin
        case (op.opcode)
            LDI:     result = op.imm;
            ADD:     result = op.operand_a + op.operand_b;
            SUB:     result = op.operand_a - op.operand_b;
            AND:     result = op.operand_a & op.operand_b;
            OR:      result = op.operand_a | op.operand_b;
            XOR:     result = op.operand_a ^ op.operand_b;
            SHL:     result = op.operand_a << op.operand_b[3:0];
            default: result = '0;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= op.valid && (op.opcode != NOP);
        end
    end

    ////////////////////////////////////////
    // Writeback payload
    ////////////////////////////////////////
    always_ff @(posedge clock) begin
        addr_q <= op.dest;
        data_q <= result;
    end

    assign wb = '{valid: valid_q, addr: addr_q, data: data_q};

endmodule

`default_nettype wire

// ==== core_top.sv ====
/*
 * Four-stage channelised compute core: fetch, decode, execute, writeback.
 * No interlocks or forwarding. A result is visible to instructions fetched
 * three or more cycles later. Host ports are only legal while not busy.
 */
`default_nettype none

module core_top import core_pkg::*; (
    input  wire logic            clock,
    input  wire logic            arst_n,
    input  wire logic            run,
    input  wire logic [ch_w:0]   n_channels,
    input  wire logic [pc_w:0]   program_size,
    input  wire logic            prog_wr,
    input  wire logic [pc_w-1:0] prog_addr,
    input  wire instr_t          prog_data,
    input  wire logic            host_wr,
    input  wire reg_addr_t       host_addr,
    input  wire data_t           host_wdata,
    output wire data_t           host_rdata,
    output wire logic            busy,
    output wire logic            done,
    output wire logic            fault
);

    wire logic [pc_w-1:0] istore_addr;
    wire fetch_t          fetch;
    wire instr_t          fetch_word;
    wire reg_addr_t       read_addr_a;
    wire reg_addr_t       read_addr_b;
    wire data_t           read_data_a;
    wire data_t           read_data_b;
    wire op_t             op;
    wire logic            illegal;
    wire wb_t             wb;

    ////////////////////////////////////////
    // Fetch
    ////////////////////////////////////////
    core_control control0 (
        .clock(clock),
        .arst_n(arst_n),
        .run(run),
        .n_channels(n_channels),
        .program_size(program_size),
        .illegal(illegal),
        .istore_addr(istore_addr),
        .fetch(fetch),
        .busy(busy),
        .done(done),
        .fault(fault)
    );

    core_istore istore0 (
        .clock(clock),
        .prog_wr(prog_wr),
        .prog_addr(prog_addr),
        .prog_data(prog_data),
        .fetch_addr(istore_addr),
        .fetch_word(fetch_word)
    );

    ////////////////////////////////////////
    // Decode, execute and writeback
    ////////////////////////////////////////
    core_decode decode0 (
        .clock(clock),
        .arst_n(arst_n),
        .fetch(fetch),
        .word(fetch_word),
        .read_addr_a(read_addr_a),
        .read_addr_b(read_addr_b),
        .read_data_a(read_data_a),
        .read_data_b(read_data_b),
        .op(op),
        .illegal(illegal)
    );

    core_execute execute0 (
        .clock(clock),
        .arst_n(arst_n),
        .op(op),
        .wb(wb)
    );

    core_regfile regfile0 (
        .clock(clock),
        .wb(wb),
        .read_addr_a(read_addr_a),
        .read_addr_b(read_addr_b),
        .read_data_a(read_data_a),
        .read_data_b(read_data_b),
        .host_wr(host_wr),
        .host_addr(host_addr),
        .host_wdata(host_wdata),
        .host_rdata(host_rdata)
    );

endmodule

`default_nettype wire

// ==== core_sva.sv ====
/*
 * Concurrent checks on the host and status rules of core_top.
 * Bound to every core_top instance. Checks are off while reset is low.
 */
`default_nettype none

module core_sva (
    input wire logic clock,
    input wire logic arst_n,
    input wire logic run,
    input wire logic prog_wr,
    input wire logic host_wr,
    input wire logic busy,
    input wire logic done,
    input wire logic fault
);

    timeunit 1ns;
    timeprecision 100ps;

    done_one_cycle: assert property (@(posedge clock) disable iff (!arst_n)
        done |=> !done)
        else $error("done stayed high for more than one cycle");

    // Host ports belong to the idle core only
    no_host_write_busy: assert property (@(posedge clock) disable iff (!arst_n)
        busy |-> !host_wr && !prog_wr)
        else $error("host or program write while the core is busy");

    done_means_idle: assert property (@(posedge clock) disable iff (!arst_n)
        done |-> !busy)
        else $error("busy still high in the done cycle");

    fault_sticky: assert property (@(posedge clock) disable iff (!arst_n)
        fault && !run |=> fault)
        else $error("fault dropped without a run pulse");

endmodule

bind core_top core_sva sva0 (
    .clock(clock),
    .arst_n(arst_n),
    .run(run),
    .prog_wr(prog_wr),
    .host_wr(host_wr),
    .busy(busy),
    .done(done),
    .fault(fault)
);

`default_nettype wire

// ==== tb_clock.sv ====
/*
 * Testbench clock and reset source. 10 ns clock period.
 * Reset is held low for 16 cycles and released on a falling edge.
 */
`default_nettype none

module tb_clock (
    output logic clock,
    output logic arst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    initial begin
        arst_n = 1'b0;
        repeat (16) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== core_tb.sv ====
/*
 * Table-driven testbench for core_top. Inputs change on the falling edge
 * and outputs are sampled there too. The first error stops the run.
 * Register and program contents are set by the host before every run.
 */
`default_nettype none

module core_tb import core_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        opcode_e op;
        data_t   a;
        data_t   b;
        data_t   imm;
        data_t   expected;
    } row_t;

    // r3 is preset to dead, so NOP must leave it alone
    localparam int n_rows = 10;
    localparam row_t rows [n_rows] = '{
        '{NOP, 16'h1111, 16'h2222, 16'h3333, 16'hdead},
        '{LDI, 16'h1111, 16'h2222, 16'h1234, 16'h1234},
        '{ADD, 16'hfff0, 16'h0025, 16'h0000, 16'h0015},
        '{ADD, 16'h7fff, 16'h0001, 16'h0000, 16'h8000},
        '{SUB, 16'h0003, 16'h0005, 16'h0000, 16'hfffe},
        '{AND, 16'hf0f0, 16'h3c3c, 16'h0000, 16'h3030},
        '{OR,  16'hf0f0, 16'h0f01, 16'h0000, 16'hfff1},
        '{XOR, 16'haaaa, 16'hffff, 16'h0000, 16'h5555},
        '{SHL, 16'h0013, 16'h0024, 16'h0000, 16'h0130},
        '{SHL, 16'h8001, 16'h0011, 16'h0000, 16'h0002}
    };

    logic            clock;
    logic            arst_n;
    logic            run;
    logic [ch_w:0]   n_channels;
    logic [pc_w:0]   program_size;
    logic            prog_wr;
    logic [pc_w-1:0] prog_addr;
    instr_t          prog_data;
    logic            host_wr;
    reg_addr_t       host_addr;
    data_t           host_wdata;
    data_t           host_rdata;
    logic            busy;
    logic            done;
    logic            fault;
    int              done_count = 0;

    tb_clock clock0 (
        .clock(clock),
        .arst_n(arst_n)
    );

    core_top dut0 (
        .clock(clock),
        .arst_n(arst_n),
        .run(run),
        .n_channels(n_channels),
        .program_size(program_size),
        .prog_wr(prog_wr),
        .prog_addr(prog_addr),
        .prog_data(prog_data),
        .host_wr(host_wr),
        .host_addr(host_addr),
        .host_wdata(host_wdata),
        .host_rdata(host_rdata),
        .busy(busy),
        .done(done),
        .fault(fault)
    );

    always @(negedge clock) begin
        if (done) begin
            done_count++;
        end
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input data_t actual, input data_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("FAIL t=%0t %s got %h expected %h",
                                $time, name, actual, expected));
        end
    endtask

    task automatic check_flag(input string name, input bit actual, input bit expected);
        if (actual !== expected) begin
            abort_run($sformatf("FAIL t=%0t %s got %b expected %b",
                                $time, name, actual, expected));
        end
    endtask

    function automatic reg_addr_t reg_at(input int ch, input int idx);
        return '{channel: ch_w'(ch), index: reg_w'(idx)};
    endfunction

    function automatic instr_t make_instr(input logic [3:0] opcode, input int dest,
                                          input int src_a, input int src_b,
                                          input data_t imm);
        return '{opcode: opcode, dest: reg_w'(dest), src_a: reg_w'(src_a),
                 src_b: reg_w'(src_b), imm: imm};
    endfunction

    task automatic wait_for_reset();
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (!arst_n) begin
            @(negedge clock);
            cycles++;
            if (cycles > 100) begin
                abort_run("reset was never released");
            end
        end
    endtask

    task automatic host_write(input reg_addr_t addr, input data_t value);
        @(negedge clock);
        host_wr    = 1'b1;
        host_addr  = addr;
        host_wdata = value;
        @(negedge clock);
        host_wr = 1'b0;
    endtask

    task automatic host_load(input int addr, input instr_t word);
        @(negedge clock);
        prog_wr   = 1'b1;
        prog_addr = pc_w'(addr);
        prog_data = word;
        @(negedge clock);
        prog_wr = 1'b0;
    endtask

    task automatic expect_reg(input string name, input reg_addr_t addr, input data_t expected);
        @(negedge clock);
        host_addr = addr;
        @(negedge clock);
        check_data(name, host_rdata, expected);
    endtask

    // Returns on the falling edge where done is seen high
    task automatic start_and_wait(input int channels, input int size, input bit run_twice);
        int cycles;
        @(negedge clock);
        n_channels   = (ch_w+1)'(channels);
        program_size = (pc_w+1)'(size);
        run          = 1'b1;
        @(negedge clock);
        run = 1'b0;
        if (run_twice) begin
            check_flag("busy", busy, 1'b1);
            run = 1'b1;
            @(negedge clock);
            run = 1'b0;
        end
        cycles = 0;
        while (!done) begin
            @(negedge clock);
            cycles++;
            if (cycles > 200) begin
                abort_run("timeout while waiting for done after run");
            end
        end
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////
    initial begin
        data_t ops_a [max_channels];
        data_t ops_b [max_channels];
        int    dones_before;
        void'($urandom(32'h545e));
        run          = 1'b0;
        n_channels   = 3'd1;
        program_size = '0;
        prog_wr      = 1'b0;
        prog_addr    = '0;
        prog_data    = '0;
        host_wr      = 1'b0;
        host_addr    = '0;
        host_wdata   = '0;

        wait_for_reset();
        check_flag("busy", busy, 1'b0);
        check_flag("done", done, 1'b0);
        check_flag("fault", fault, 1'b0);

        // One instruction per row on channel 0
        for (int i = 0; i < n_rows; i++) begin
            host_write(reg_at(0, 1), rows[i].a);
            host_write(reg_at(0, 2), rows[i].b);
            host_write(reg_at(0, 3), 16'hdead);
            host_load(0, make_instr(rows[i].op, 3, 1, 2, rows[i].imm));
            start_and_wait(1, 1, 1'b0);
            expect_reg($sformatf("row %0d r3", i), reg_at(0, 3), rows[i].expected);
        end

        // Four banks share one ADD
        for (int ch = 0; ch < max_channels; ch++) begin
            ops_a[ch] = data_t'($urandom);
            ops_b[ch] = data_t'($urandom);
            host_write(reg_at(ch, 1), ops_a[ch]);
            host_write(reg_at(ch, 2), ops_b[ch]);
            host_write(reg_at(ch, 5), data_t'(16'h0c50 + ch));
        end
        host_load(0, make_instr(ADD, 3, 1, 2, 16'h0000));
        start_and_wait(4, 1, 1'b0);
        for (int ch = 0; ch < max_channels; ch++) begin
            expect_reg($sformatf("ch%0d r3", ch), reg_at(ch, 3), data_t'(ops_a[ch] + ops_b[ch]));
            expect_reg($sformatf("ch%0d r1", ch), reg_at(ch, 1), ops_a[ch]);
            expect_reg($sformatf("ch%0d r2", ch), reg_at(ch, 2), ops_b[ch]);
            expect_reg($sformatf("ch%0d r5", ch), reg_at(ch, 5), data_t'(16'h0c50 + ch));
        end

        // LDI then ADD four fetches later
        host_write(reg_at(0, 1), 16'h0000);
        host_write(reg_at(0, 2), 16'h0000);
        host_load(0, make_instr(LDI, 1, 0, 0, 16'h0321));
        host_load(1, make_instr(NOP, 0, 0, 0, 16'h0000));
        host_load(2, make_instr(NOP, 0, 0, 0, 16'h0000));
        host_load(3, make_instr(NOP, 0, 0, 0, 16'h0000));
        host_load(4, make_instr(ADD, 2, 1, 1, 16'h0000));
        start_and_wait(1, 5, 1'b0);
        expect_reg("dependent r1", reg_at(0, 1), 16'h0321);
        expect_reg("dependent r2", reg_at(0, 2), 16'h0642);

        // Opcode 12 is outside the instruction set
        host_write(reg_at(0, 3), 16'h5a5a);
        host_load(0, make_instr(4'd12, 3, 1, 2, 16'hffff));
        start_and_wait(1, 1, 1'b0);
        check_flag("fault", fault, 1'b1);
        expect_reg("illegal r3", reg_at(0, 3), 16'h5a5a);
        host_load(0, make_instr(NOP, 0, 0, 0, 16'h0000));
        start_and_wait(1, 1, 1'b0);
        check_flag("fault", fault, 1'b0);

        // Second run pulse lands while busy
        host_write(reg_at(0, 1), 16'h1234);
        host_write(reg_at(0, 2), 16'h0101);
        host_write(reg_at(0, 3), 16'h0000);
        host_load(0, make_instr(ADD, 3, 1, 2, 16'h0000));
        dones_before = done_count;
        start_and_wait(1, 1, 1'b1);
        repeat (10) @(negedge clock);
        check_data("done pulses", data_t'(done_count - dones_before), 16'd1);
        expect_reg("rerun r3", reg_at(0, 3), 16'h1335);

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== core.f ====
core_pkg.sv
core_control.sv
core_istore.sv
core_decode.sv
core_regfile.sv
core_execute.sv
core_top.sv
core_sva.sv
tb_clock.sv
core_tb.sv

// ==== Makefile ====
# Verilator flow for the channelised compute core
TOP := core_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f core.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f core.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
